// ==== logic/rv_pkg.sv ====
`default_nettype none

package rv_pkg;

  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;
  localparam int NUM_REGS   = 1 << REG_ADDR_W;

  // Shift amount comes from the low bits of operand B
  localparam int SHAMT_W = $clog2(XLEN);

  localparam logic [6:0] FUNCT7_BASE = 7'h00;
  localparam logic [6:0] FUNCT7_ALT  = 7'h20;

  // Major opcodes handled by the execute subsystem
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_SLT,
    ALU_SLTU,
    ALU_PASS_B
  } alu_op_e;

  // Decoder output, before the register read
  typedef struct packed {
    alu_op_e               alu_op;
    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;
    logic [REG_ADDR_W-1:0] rd;
    logic [XLEN-1:0]       imm;
    logic                  use_imm;
    logic                  zero_a;
  } dec_t;

  // Execute stage register contents
  typedef struct packed {
    alu_op_e               alu_op;
    logic [XLEN-1:0]       a;
    logic [XLEN-1:0]       b;
    logic [REG_ADDR_W-1:0] rd;
  } ex_t;

  typedef struct packed {
    logic [REG_ADDR_W-1:0] rd;
    logic [XLEN-1:0]       data;
  } wb_t;

endpackage

`default_nettype wire

// ==== logic/rv_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_decoder
  import rv_pkg::*;
(
  input  logic [XLEN-1:0] instr,
  output dec_t            dec,
  output logic            legal
);

  opcode_e    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       funct7_base;
  logic       funct7_alt;
  logic       alt_allowed;
  logic       is_shift;

  // Shared funct3 mapping for OP and OP-IMM
  function automatic alu_op_e funct3_op(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  funct3_op = alt ? ALU_SUB : ALU_ADD;
      3'b001:  funct3_op = ALU_SLL;
      3'b010:  funct3_op = ALU_SLT;
      3'b011:  funct3_op = ALU_SLTU;
      3'b100:  funct3_op = ALU_XOR;
      3'b101:  funct3_op = alt ? ALU_SRA : ALU_SRL;
      3'b110:  funct3_op = ALU_OR;
      default: funct3_op = ALU_AND;
    endcase
  endfunction

  assign opcode = opcode_e'(instr[6:0]);
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  assign funct7_base = (funct7 == FUNCT7_BASE);
  assign funct7_alt  = (funct7 == FUNCT7_ALT);

  // Only SUB and SRA/SRAI have an alternate encoding
  assign alt_allowed = (funct3 == 3'b000) || (funct3 == 3'b101);
  assign is_shift    = (funct3[1:0] == 2'b01);

  always_comb begin
    dec         = '0;
    dec.alu_op  = ALU_ADD;
    dec.rs1     = instr[19:15];
    dec.rs2     = instr[24:20];
    dec.rd      = instr[11:7];
    dec.imm     = {{(XLEN-12){instr[31]}}, instr[31:20]};
    dec.use_imm = 1'b0;
    dec.zero_a  = 1'b0;
    legal       = 1'b0;

    case (opcode)
      OPC_OP: begin
        dec.alu_op = funct3_op(funct3, funct7_alt);
        legal      = funct7_base || (funct7_alt && alt_allowed);
      end

      OPC_OP_IMM: begin
        dec.use_imm = 1'b1;
        // ADDI has no SUB form, so alt only counts for right shifts
        dec.alu_op  = funct3_op(funct3, funct7_alt && (funct3 == 3'b101));
        if (is_shift) begin
          legal = funct7_base || (funct7_alt && funct3[2]);
        end else begin
          legal = 1'b1;
        end
      end

      OPC_LUI: begin
        dec.alu_op  = ALU_PASS_B;
        dec.imm     = {instr[31:12], 12'b0};
        dec.use_imm = 1'b1;
        dec.zero_a  = 1'b1;
        legal       = 1'b1;
      end

      default: begin
        legal = 1'b0;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== logic/rv_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_regfile
  import rv_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [REG_ADDR_W-1:0] rs1_addr,
  input  logic [REG_ADDR_W-1:0] rs2_addr,
  output logic [XLEN-1:0]       rs1_data,
  output logic [XLEN-1:0]       rs2_data,
  input  logic                  wr_en,
  input  wb_t                   wr
);

  // x0 has no storage
  logic [XLEN-1:0] regs [1:NUM_REGS-1];
  logic            wr_active;
  logic            rs1_fwd;
  logic            rs2_fwd;

  assign wr_active = wr_en && (wr.rd != '0);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 1; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_active) begin
      regs[wr.rd] <= wr.data;
    end
  end

  // Write-through so a dependent read in the same cycle sees the new value
  assign rs1_fwd = wr_active && (rs1_addr == wr.rd);
  assign rs2_fwd = wr_active && (rs2_addr == wr.rd);

  always_comb begin
    if (rs1_addr == '0) begin
      rs1_data = '0;
    end else if (rs1_fwd) begin
      rs1_data = wr.data;
    end else begin
      rs1_data = regs[rs1_addr];
    end
  end

  always_comb begin
    if (rs2_addr == '0) begin
      rs2_data = '0;
    end else if (rs2_fwd) begin
      rs2_data = wr.data;
    end else begin
      rs2_data = regs[rs2_addr];
    end
  end

  // Known addresses after reset must give known data
  a_read_known: assert property (
    @(posedge clk) disable iff (!rst_n)
    !$isunknown({rs1_addr, rs2_addr}) |-> !$isunknown({rs1_data, rs2_data})
  );

endmodule

`default_nettype wire

// ==== logic/rv_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_alu
  import rv_pkg::*;
(
  input  ex_t             ex,
  output logic [XLEN-1:0] result
);

  logic [SHAMT_W-1:0] shamt;
  logic               lt_signed;
  logic               lt_unsigned;

  assign shamt = ex.b[SHAMT_W-1:0];

  assign lt_signed   = $signed(ex.a) < $signed(ex.b);
  assign lt_unsigned = ex.a < ex.b;

  always_comb begin
    case (ex.alu_op)
      ALU_ADD: begin
        result = ex.a + ex.b;
      end
      ALU_SUB: begin
        result = ex.a - ex.b;
      end
      ALU_AND: begin
        result = ex.a & ex.b;
      end
      ALU_OR: begin
        result = ex.a | ex.b;
      end
      ALU_XOR: begin
        result = ex.a ^ ex.b;
      end
      ALU_SLL: begin
        result = ex.a << shamt;
      end
      ALU_SRL: begin
        result = ex.a >> shamt;
      end
      ALU_SRA: begin
        // Sign bit fills from the left
        result = $signed(ex.a) >>> shamt;
      end
      ALU_SLT: begin
        result = XLEN'(lt_signed);
      end
      ALU_SLTU: begin
        result = XLEN'(lt_unsigned);
      end
      ALU_PASS_B: begin
        result = ex.b;
      end
      default: begin
        result = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== logic/rv_exec_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_exec_core
  import rv_pkg::*;
(
  input  logic            clk,
  input  logic            rst_n,
  input  logic            instr_valid,
  input  logic [XLEN-1:0] instr,
  output logic            wb_valid,
  output wb_t             wb,
  output logic            illegal
);

  dec_t            dec;
  logic            legal;
  logic            issue;
  logic [XLEN-1:0] rs1_data;
  logic [XLEN-1:0] rs2_data;
  ex_t             ex_next;
  ex_t             ex_q;
  logic            ex_valid;
  logic [XLEN-1:0] alu_result;
  wb_t             ex_wr;

  rv_decoder u_decoder (
    .instr (instr),
    .dec   (dec),
    .legal (legal)
  );

  // Read ports sit in the decode cycle, the write port in execute
  rv_regfile u_regfile (
    .clk      (clk),
    .rst_n    (rst_n),
    .rs1_addr (dec.rs1),
    .rs2_addr (dec.rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .wr_en    (ex_valid),
    .wr       (ex_wr)
  );

  assign issue = instr_valid && legal;

  // Operand select
  always_comb begin
    ex_next.alu_op = dec.alu_op;
    ex_next.a      = dec.zero_a ? '0 : rs1_data;
    ex_next.b      = dec.use_imm ? dec.imm : rs2_data;
    ex_next.rd     = dec.rd;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ex_valid <= 1'b0;
      wb_valid <= 1'b0;
      illegal  <= 1'b0;
    end else begin
      ex_valid <= issue;
      wb_valid <= ex_valid;
      illegal  <= instr_valid && !legal;
    end
  end

  always_ff @(posedge clk) begin
    if (issue) begin
      ex_q <= ex_next;
    end
  end

  rv_alu u_alu (
    .ex     (ex_q),
    .result (alu_result)
  );

  assign ex_wr.rd   = ex_q.rd;
  assign ex_wr.data = alu_result;

  // Writeback register mirrors the register file commit
  always_ff @(posedge clk) begin
    if (ex_valid) begin
      wb <= ex_wr;
    end
  end

  // Dependent decode right behind a write sees the ALU result
  a_fwd_rs1: assert property (
    @(posedge clk) disable iff (!rst_n)
    (ex_valid && ex_wr.rd != '0 && dec.rs1 == ex_wr.rd) |-> (rs1_data == ex_wr.data)
  );

  a_fwd_rs2: assert property (
    @(posedge clk) disable iff (!rst_n)
    (ex_valid && ex_wr.rd != '0 && dec.rs2 == ex_wr.rd) |-> (rs2_data == ex_wr.data)
  );

endmodule

`default_nettype wire

// ==== bench/rv_exec_core_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_exec_core_tb
  import rv_pkg::*;
;

  localparam int    SEED        = 84814;
  localparam int    RESET_CYCLES = 5;
  localparam string VEC_FILE    = "bench/rv_exec_vectors.txt";

  logic            clk;
  logic            rst_n;
  logic            instr_valid;
  logic [XLEN-1:0] instr;
  logic            wb_valid;
  wb_t             wb;
  logic            illegal;

  // Vectors as read from the file
  logic [XLEN-1:0] vec_instr [$];
  logic            vec_ill [$];
  logic            vec_b2b [$];
  wb_t             vec_wb [$];

  // Expected outcomes in program order
  wb_t             wb_q [$];
  logic            ill_q [$];

  logic            strobe_d = 1'b0;
  int              errors = 0;
  int              wb_count = 0;
  int              ill_count = 0;
  int              n_legal = 0;
  int              cycles = 0;
  int              cycle_limit = 0;

  rv_exec_core dut0 (
    .clk         (clk),
    .rst_n       (rst_n),
    .instr_valid (instr_valid),
    .instr       (instr),
    .wb_valid    (wb_valid),
    .wb          (wb),
    .illegal     (illegal)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic check_wb(input wb_t exp, input wb_t act);
    if (act.rd !== exp.rd) begin
      $display("ERROR %0t wb.rd: expected %0d, got %0d", $time, exp.rd, act.rd);
      errors++;
    end
    if (act.data !== exp.data) begin
      $display("ERROR %0t wb.data: expected %h, got %h", $time, exp.data, act.data);
      errors++;
    end
  endtask

  task automatic check_illegal(input logic exp, input logic act);
    if (act !== exp) begin
      $display("ERROR %0t illegal: expected %b, got %b", $time, exp, act);
      errors++;
    end
  endtask

  task automatic load_vectors();
    int              fd;
    int              code;
    string           line;
    logic [31:0]     f_instr;
    logic [31:0]     f_ill;
    logic [31:0]     f_rd;
    logic [31:0]     f_data;
    logic [31:0]     f_b2b;
    wb_t             w;
    fd = $fopen(VEC_FILE, "r");
    if (fd == 0) begin
      $display("Could not open the vector file %s", VEC_FILE);
      errors++;
    end else begin
      while (!$feof(fd)) begin
        code = $fgets(line, fd);
        // Header and blank lines do not scan as five fields
        if (code > 0 &&
            $sscanf(line, "%h %h %h %h %h", f_instr, f_ill, f_rd, f_data, f_b2b) == 5) begin
          w.rd   = f_rd[REG_ADDR_W-1:0];
          w.data = f_data;
          vec_instr.push_back(f_instr);
          vec_ill.push_back(f_ill[0]);
          vec_b2b.push_back(f_b2b[0]);
          vec_wb.push_back(w);
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      instr_valid <= 1'b0;
    end
  endtask

  task automatic run_vectors();
    int gap;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    for (int i = 0; i < vec_instr.size(); i++) begin
      // Dependent chains go out with no idle cycles
      if (i > 0 && !vec_b2b[i]) begin
        gap = $urandom_range(2, 0);
        idle_cycles(gap);
      end
      @(posedge clk);
      instr_valid <= 1'b1;
      instr       <= vec_instr[i];
      ill_q.push_back(vec_ill[i]);
      if (!vec_ill[i]) begin
        wb_q.push_back(vec_wb[i]);
        n_legal++;
      end
    end
    idle_cycles(1);
    while (wb_q.size() != 0 || ill_q.size() != 0) begin
      @(posedge clk);
    end
    // A few more cycles to catch stray outputs
    repeat (3) @(posedge clk);
  endtask

  // Strobe seen in the previous cycle
  always @(posedge clk) begin
    strobe_d <= rst_n && instr_valid;
  end

  always @(negedge clk) begin
    logic exp_ill;
    wb_t  exp_wb;
    if (rst_n) begin
      if (illegal) begin
        ill_count++;
      end
      if (strobe_d) begin
        exp_ill = ill_q.pop_front();
        check_illegal(exp_ill, illegal);
      end else if (illegal) begin
        $display("Illegal strobe at %0t ns without an instruction", $time);
        errors++;
      end
      if (wb_valid) begin
        wb_count++;
        if (wb_q.size() == 0) begin
          $display("Writeback at %0t ns arrived with no writeback expected", $time);
          errors++;
        end else begin
          exp_wb = wb_q.pop_front();
          check_wb(exp_wb, wb);
        end
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycle_limit > 0 && cycles >= cycle_limit) begin
      $display("Timeout after %0d cycles, %0d writebacks still outstanding",
               cycles, wb_q.size());
      $display("Summary: %0d writebacks, %0d illegal strobes, %0d errors",
               wb_count, ill_count, errors + 1);
      $display("Errors found");
      $finish;
    end
  end

  initial begin
    rst_n       = 1'b0;
    instr_valid = 1'b0;
    instr       = '0;
    void'($urandom(SEED));
    load_vectors();
    if (vec_instr.size() == 0) begin
      $display("No vectors were loaded, nothing to run");
      errors++;
    end else begin
      // Worst case is three cycles per instruction plus reset and drain
      cycle_limit = 4 * vec_instr.size() + 50;
      run_vectors();
      if (wb_count != n_legal) begin
        $display("ERROR %0t wb count: expected %0d, got %0d", $time, n_legal, wb_count);
        errors++;
      end
    end
    $display("Summary: %0d writebacks, %0d illegal strobes, %0d errors",
             wb_count, ill_count, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== bench/rv_exec_vectors.txt ====
# instr    illegal  rd  result    back_to_back (all hex)
# illegal lines carry rd and result as zero, back_to_back=1 means no idle cycles before
00500013 0 00 00000005 0
000000B3 0 01 00000000 0
12300093 0 01 00000123 0
FFF00113 0 02 FFFFFFFF 0
800001B7 0 03 80000000 0
00700213 0 04 00000007 0
004082B3 0 05 0000012A 0
40120333 0 06 FFFFFEE4 0
001173B3 0 07 00000123 0
0041E433 0 08 80000007 0
0020C4B3 0 09 FFFFFEDC 0
00409533 0 0A 00009180 0
0041D5B3 0 0B 01000000 0
4041D633 0 0C FF000000 0
0041A6B3 0 0D 00000001 0
0041B733 0 0E 00000000 0
00012793 0 0F 00000001 0
FFF23813 0 10 00000001 0
0FF0C893 0 11 000001DC 0
7F026913 0 12 000007F7 0
55517993 0 13 00000555 0
01C21A13 0 14 70000000 0
00415A93 0 15 0FFFFFFF 0
4041DB13 0 16 F8000000 0
EDC08B93 0 17 FFFFFFFF 0
01100C13 0 18 00000011 0
02108CB3 1 00 00000000 0
018C0CB3 0 19 00000022 0
0000AD03 1 00 00000000 0
4010ED33 1 00 00000000 0
40109D13 1 00 00000000 0
001C8D13 0 1A 00000023 0
00100D93 0 1B 00000001 1
01BD8DB3 0 1B 00000002 1
01BD8DB3 0 1B 00000004 1
003D9E13 0 1C 00000020 1
41BE0EB3 0 1D 0000001C 1
01CECF33 0 1E 0000003C 1
ABCDEFB7 0 1F ABCDE000 1
0F0FEF93 0 1F ABCDE0F0 1
01FF8333 0 06 579BC1E0 1
0000007F 1 00 00000000 1
01EF80B3 0 01 ABCDE12C 1
01618133 0 02 78000000 0
015A41B3 0 03 7FFFFFFF 0
01798233 0 04 00000554 0
00130433 0 08 0369A30C 0

// ==== src.f ====
logic/rv_pkg.sv
logic/rv_decoder.sv
logic/rv_regfile.sv
logic/rv_alu.sv
logic/rv_exec_core.sv
bench/rv_exec_core_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the execute core testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert \
  -f src.f \
  --top-module rv_exec_core_tb \
  -o rv_exec_sim

./obj_dir/rv_exec_sim | tee "$LOG"

if grep -q "Errors found" "$LOG"; then
  echo "Simulation FAILED, see $LOG"
  exit 1
fi

echo "Simulation passed"
exit 0
